//--- hw/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [2:0]            func3_t;
    typedef logic [6:0]            funct7_t;
    typedef logic [6:0]            opcode_t;

    // Major opcodes handled by this slice.
    localparam opcode_t op_op    = 7'b0110011;
    localparam opcode_t op_imm   = 7'b0010011;
    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_auipc = 7'b0010111;

    localparam func3_t f3_add_sub = 3'b000;
    localparam func3_t f3_sll     = 3'b001;
    localparam func3_t f3_slt     = 3'b010;
    localparam func3_t f3_sltu    = 3'b011;
    localparam func3_t f3_xor     = 3'b100;
    localparam func3_t f3_srl_sra = 3'b101;
    localparam func3_t f3_or      = 3'b110;
    localparam func3_t f3_and     = 3'b111;

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000; // SUB and SRA.

    localparam reg_addr_t nop_reg_addr = '0;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

    typedef enum logic {
        src1_reg = 1'b0,
        src1_pc  = 1'b1
    } src1_sel_t;

    typedef enum logic {
        src2_reg = 1'b0,
        src2_imm = 1'b1
    } src2_sel_t;

endpackage

//--- hw/pipe_pkg.sv
package pipe_pkg;

    // Fetch side of the input port.
    typedef struct packed {
        cpu_pkg::word_t pc;
        cpu_pkg::word_t instr;
    } fetch_t;

    typedef struct packed {
        logic                   valid;
        cpu_pkg::word_t         pc;
        cpu_pkg::alu_op_t       alu_op;
        cpu_pkg::src1_sel_t     src1_sel;
        cpu_pkg::src2_sel_t     src2_sel;
        cpu_pkg::word_t         imm;
        cpu_pkg::reg_addr_t     rs1_addr;
        cpu_pkg::word_t         rs1_data;
        cpu_pkg::reg_addr_t     rs2_addr;
        cpu_pkg::word_t         rs2_data;
        cpu_pkg::reg_addr_t     rd;
        logic                   wreg;
        logic                   illegal;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        cpu_pkg::word_t     pc;
        cpu_pkg::reg_addr_t rd;
        logic               wreg;
        cpu_pkg::word_t     result;
        logic               illegal;
    } ex_wb_t;

    typedef struct packed {
        cpu_pkg::word_t     pc;
        cpu_pkg::reg_addr_t rd;
        logic               wen;
        cpu_pkg::word_t     wdata;
        logic               illegal;
    } retire_t;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rstn,
    input  cpu_pkg::reg_addr_t ra1,
    input  cpu_pkg::reg_addr_t ra2,
    output cpu_pkg::word_t     rd1,
    output cpu_pkg::word_t     rd2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wa,
    input  cpu_pkg::word_t     wd
);

    cpu_pkg::word_t regs [1:2**cpu_pkg::reg_addr_w-1]; // x0 has no storage.

    function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_addr_t ra);
        cpu_pkg::word_t data;
        if (ra == cpu_pkg::nop_reg_addr)
            data = '0;
        else if (we && wa == ra)
            data = wd;              // Same-cycle write goes straight through.
        else
            data = regs[ra];
        return data;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < 2**cpu_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != cpu_pkg::nop_reg_addr) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

//--- hw/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic               in_valid,
    input  logic               in_ready,
    input  pipe_pkg::fetch_t   in_data,
    output cpu_pkg::reg_addr_t ra1,
    output cpu_pkg::reg_addr_t ra2,
    input  cpu_pkg::word_t     rd1,
    input  cpu_pkg::word_t     rd2,
    output pipe_pkg::id_ex_t   dec
);

    cpu_pkg::opcode_t   opcode;
    cpu_pkg::func3_t    funct3;
    cpu_pkg::funct7_t   funct7;
    cpu_pkg::reg_addr_t rd_f;
    cpu_pkg::word_t     imm_i;
    cpu_pkg::word_t     imm_u;
    cpu_pkg::alu_op_t   op3;
    logic               f7_ok_op;
    logic               f7_ok_imm;
    logic               illegal;

    assign opcode = in_data.instr[6:0];
    assign rd_f   = in_data.instr[11:7];
    assign funct3 = in_data.instr[14:12];
    assign funct7 = in_data.instr[31:25];
    assign ra1    = in_data.instr[19:15];
    assign ra2    = in_data.instr[24:20];

    assign imm_i = {{20{in_data.instr[31]}}, in_data.instr[31:20]};
    assign imm_u = {in_data.instr[31:12], 12'b0};

    // ALU op from funct3; bit 30 selects SUB only for register ops.
    always_comb begin
        op3       = cpu_pkg::alu_add;
        f7_ok_op  = (funct7 == cpu_pkg::f7_base);
        f7_ok_imm = 1'b1;
        case (funct3)
            cpu_pkg::f3_add_sub: begin
                op3 = (opcode == cpu_pkg::op_op && funct7 == cpu_pkg::f7_alt) ?
                      cpu_pkg::alu_sub : cpu_pkg::alu_add;
                f7_ok_op = f7_ok_op || funct7 == cpu_pkg::f7_alt;
            end
            cpu_pkg::f3_sll: begin
                op3       = cpu_pkg::alu_sll;
                f7_ok_imm = (funct7 == cpu_pkg::f7_base);
            end
            cpu_pkg::f3_slt:  op3 = cpu_pkg::alu_slt;
            cpu_pkg::f3_sltu: op3 = cpu_pkg::alu_sltu;
            cpu_pkg::f3_xor:  op3 = cpu_pkg::alu_xor;
            cpu_pkg::f3_srl_sra: begin
                op3 = (funct7 == cpu_pkg::f7_alt) ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
                f7_ok_op  = f7_ok_op || funct7 == cpu_pkg::f7_alt;
                f7_ok_imm = f7_ok_op;
            end
            cpu_pkg::f3_or:   op3 = cpu_pkg::alu_or;
            default:          op3 = cpu_pkg::alu_and;
        endcase
    end

    always_comb begin
        dec          = '0;
        illegal      = 1'b0;
        dec.alu_op   = op3;
        dec.src1_sel = cpu_pkg::src1_reg;
        dec.src2_sel = cpu_pkg::src2_reg;
        dec.imm      = imm_i;
        case (opcode)
            cpu_pkg::op_op:  illegal = !f7_ok_op;
            cpu_pkg::op_imm: begin
                dec.src2_sel = cpu_pkg::src2_imm;
                illegal      = !f7_ok_imm;
            end
            cpu_pkg::op_lui: begin
                dec.alu_op   = cpu_pkg::alu_pass_b;
                dec.src2_sel = cpu_pkg::src2_imm;
                dec.imm      = imm_u;
            end
            cpu_pkg::op_auipc: begin
                dec.alu_op   = cpu_pkg::alu_add;
                dec.src1_sel = cpu_pkg::src1_pc;
                dec.src2_sel = cpu_pkg::src2_imm;
                dec.imm      = imm_u;
            end
            default: illegal = 1'b1;
        endcase
        dec.valid    = in_valid && in_ready;
        dec.pc       = in_data.pc;
        dec.rs1_addr = ra1;
        dec.rs1_data = rd1;
        dec.rs2_addr = ra2;
        dec.rs2_data = rd2;
        dec.rd       = rd_f;
        dec.wreg     = !illegal && rd_f != cpu_pkg::nop_reg_addr;
        dec.illegal  = illegal;
    end

endmodule

//--- hw/id_ex.sv
`timescale 1ns/1ps

module id_ex (
    input  logic             clk,
    input  logic             rstn,
    input  logic             hold,
    input  logic             flush,
    input  pipe_pkg::id_ex_t id,
    output pipe_pkg::id_ex_t ex
);

    pipe_pkg::id_ex_t bubble;

    // Empty slot: no valid, no write, rd is x0.
    always_comb begin
        bubble          = ex;
        bubble.valid    = 1'b0;
        bubble.wreg     = 1'b0;
        bubble.illegal  = 1'b0;
        bubble.rd       = cpu_pkg::nop_reg_addr;
        bubble.alu_op   = cpu_pkg::alu_add;
        bubble.src1_sel = cpu_pkg::src1_reg;
        bubble.src2_sel = cpu_pkg::src2_reg;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex <= '0;
        end else if (flush) begin
            ex <= bubble;         // Flush wins over hold.
        end else if (!hold) begin
            ex <= id;
        end
    end

    // A flushed slot never reaches execute.
    assert property (@(posedge clk) disable iff (!rstn)
        flush && !hold |=> !ex.valid);

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  pipe_pkg::id_ex_t ex,
    input  pipe_pkg::ex_wb_t wb_fwd,
    output pipe_pkg::ex_wb_t res
);

    cpu_pkg::word_t rs1_val;
    cpu_pkg::word_t rs2_val;
    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t result;
    logic [4:0]     shamt;
    logic           fwd_ok;

    // The result register holds the only instruction ahead of this one.
    assign fwd_ok = wb_fwd.valid && wb_fwd.wreg;

    always_comb begin
        rs1_val = ex.rs1_data;
        rs2_val = ex.rs2_data;
        if (fwd_ok && wb_fwd.rd == ex.rs1_addr)
            rs1_val = wb_fwd.result;
        if (fwd_ok && wb_fwd.rd == ex.rs2_addr)
            rs2_val = wb_fwd.result;
    end

    assign op_a  = (ex.src1_sel == cpu_pkg::src1_pc)  ? ex.pc  : rs1_val;
    assign op_b  = (ex.src2_sel == cpu_pkg::src2_imm) ? ex.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        result = '0;
        case (ex.alu_op)
            cpu_pkg::alu_add:  result = op_a + op_b;
            cpu_pkg::alu_sub:  result = op_a - op_b;
            cpu_pkg::alu_sll:  result = op_a << shamt;
            cpu_pkg::alu_slt:  result = cpu_pkg::word_t'($signed(op_a) < $signed(op_b));
            cpu_pkg::alu_sltu: result = cpu_pkg::word_t'(op_a < op_b);
            cpu_pkg::alu_xor:  result = op_a ^ op_b;
            cpu_pkg::alu_srl:  result = op_a >> shamt;
            cpu_pkg::alu_sra:  result = cpu_pkg::word_t'($signed(op_a) >>> shamt);
            cpu_pkg::alu_or:   result = op_a | op_b;
            cpu_pkg::alu_and:  result = op_a & op_b;
            cpu_pkg::alu_pass_b: result = op_b; // LUI.
            default:           result = '0;
        endcase
    end

    always_comb begin
        res.valid   = ex.valid;
        res.pc      = ex.pc;
        res.rd      = ex.rd;
        res.wreg    = ex.wreg;
        res.result  = result;
        res.illegal = ex.illegal;
    end

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic               clk,
    input  logic               rstn,
    input  logic               hold,
    input  pipe_pkg::ex_wb_t   res,
    output pipe_pkg::ex_wb_t   wb,
    output logic               out_valid,
    input  logic               out_ready,
    output pipe_pkg::retire_t  out_data,
    output logic               we,
    output cpu_pkg::reg_addr_t wa,
    output cpu_pkg::word_t     wd
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb <= '0;
        end else if (!hold) begin
            wb <= res;
        end
    end

    assign out_valid = wb.valid;

    always_comb begin
        out_data.pc      = wb.pc;
        out_data.rd      = wb.rd;
        out_data.wen     = wb.wreg;
        out_data.wdata   = wb.result;
        out_data.illegal = wb.illegal;
    end

    // Register file is written only on the retire handshake.
    assign we = wb.valid && wb.wreg && out_ready;
    assign wa = wb.rd;
    assign wd = wb.result;

    assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // Writes to x0 are never reported.
    assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> !(out_data.wen && out_data.rd == cpu_pkg::nop_reg_addr));

endmodule

//--- hw/alu_core.sv
`timescale 1ns/1ps

module alu_core (
    input  logic              clk,
    input  logic              rstn,
    input  logic              flush,
    input  logic              in_valid,
    output logic              in_ready,
    input  pipe_pkg::fetch_t  in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output pipe_pkg::retire_t out_data
);

    logic               hold;
    cpu_pkg::reg_addr_t ra1;
    cpu_pkg::reg_addr_t ra2;
    cpu_pkg::word_t     rd1;
    cpu_pkg::word_t     rd2;
    logic               we;
    cpu_pkg::reg_addr_t wa;
    cpu_pkg::word_t     wd;
    pipe_pkg::id_ex_t   dec;
    pipe_pkg::id_ex_t   ex;
    pipe_pkg::ex_wb_t   res;
    pipe_pkg::ex_wb_t   wb;

    // Retire back-pressure is the only stall source.
    assign hold     = out_valid && !out_ready;
    assign in_ready = !hold && !flush;

    reg_file rf_i (
        .clk(clk), .rstn(rstn),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .we(we), .wa(wa), .wd(wd)
    );

    id_stage id_i (
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .dec(dec)
    );

    id_ex id_ex_i (
        .clk(clk), .rstn(rstn), .hold(hold), .flush(flush),
        .id(dec), .ex(ex)
    );

    ex_stage ex_i (
        .ex(ex), .wb_fwd(wb), .res(res)
    );

    wb_stage wb_i (
        .clk(clk), .rstn(rstn), .hold(hold), .res(res), .wb(wb),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .we(we), .wa(wa), .wd(wd)
    );

endmodule

//--- sim/retire_checker.sv
`timescale 1ns/1ps

module retire_checker (
    input  logic              clk,
    input  logic              rstn,
    input  logic              flush,
    input  logic              in_valid,
    input  logic              in_ready,
    input  pipe_pkg::fetch_t  in_data,
    input  logic              out_valid,
    input  logic              out_ready,
    input  pipe_pkg::retire_t out_data,
    output logic              err
);

    cpu_pkg::word_t   regs [32];
    pipe_pkg::fetch_t pend [$];
    logic             flagged [$];  // Dropped from id_ex by a flush.
    logic             seen_accept;
    int               retired;
    int               outstanding;

    initial begin
        err         = 1'b0;
        seen_accept = 1'b0;
        retired     = 0;
        outstanding = 0;
        foreach (regs[i]) regs[i] = '0;
    end

    task automatic flag_error(input string msg);
        $display("%s", msg);
        err = 1'b1;
    endtask

    task automatic mismatch(input string test, input cpu_pkg::word_t exp,
                            input cpu_pkg::word_t act);
        $display("Mismatch in %s: expected %h, actual %h", test, exp, act);
        err = 1'b1;
    endtask

    // RV32I legality for the four supported opcodes.
    function automatic logic is_illegal(input cpu_pkg::word_t instr);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        if (opc == cpu_pkg::op_lui || opc == cpu_pkg::op_auipc)
            return 1'b0;
        if (opc == cpu_pkg::op_op)
            return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        if (opc == cpu_pkg::op_imm) begin
            if (f3 == 3'd1)
                return f7 != 7'h00;
            if (f3 == 3'd5)
                return !(f7 == 7'h00 || f7 == 7'h20);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic cpu_pkg::word_t model_result(input cpu_pkg::word_t instr,
                                                    input cpu_pkg::word_t pc);
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t imm_u;
        logic           alt;
        imm_u = {instr[31:12], 12'b0};
        if (instr[6:0] == cpu_pkg::op_lui)
            return imm_u;
        if (instr[6:0] == cpu_pkg::op_auipc)
            return pc + imm_u;
        a   = regs[instr[19:15]];
        b   = (instr[6:0] == cpu_pkg::op_op) ? regs[instr[24:20]]
                                               : {{20{instr[31]}}, instr[31:20]};
        alt = instr[30];
        case (instr[14:12])
            3'd0: return (alt && instr[6:0] == cpu_pkg::op_op) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? cpu_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Accepted instructions that no flush dropped and that have not retired.
    function automatic int unretired_count();
        int n;
        n = 0;
        foreach (flagged[i]) begin
            if (!flagged[i])
                n++;
        end
        return n;
    endfunction

    task automatic check_retire();
        pipe_pkg::fetch_t head;
        logic             ill;
        logic             found;
        cpu_pkg::word_t   exp;
        found = 1'b0;
        while (!found && pend.size() > 0) begin
            if (pend[0].pc == out_data.pc) begin
                found = 1'b1;
            end else if (flagged[0]) begin
                void'(pend.pop_front());  // Dropped by a flush.
                void'(flagged.pop_front());
            end else begin
                mismatch("retire order", pend[0].pc, out_data.pc);
                return;
            end
        end
        if (!found) begin
            flag_error("An instruction retired that was never accepted.");
            return;
        end
        head = pend.pop_front();
        void'(flagged.pop_front());
        ill  = is_illegal(head.instr);
        exp  = model_result(head.instr, head.pc);
        retired++;
        if (out_data.illegal !== ill)
            mismatch("illegal flag", cpu_pkg::word_t'(ill), cpu_pkg::word_t'(out_data.illegal));
        else if (out_data.rd !== head.instr[11:7])
            mismatch("retired rd", cpu_pkg::word_t'(head.instr[11:7]),
                     cpu_pkg::word_t'(out_data.rd));
        else if (out_data.wen !== (!ill && head.instr[11:7] != 5'd0))
            mismatch("write enable", cpu_pkg::word_t'(!ill && head.instr[11:7] != 5'd0),
                     cpu_pkg::word_t'(out_data.wen));
        else if (!ill && out_data.wdata !== exp)
            mismatch("result value", exp, out_data.wdata);
        else if (out_data.wen)
            regs[out_data.rd] = out_data.wdata;
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            if (out_valid && out_ready)
                check_retire();
            // Only a stalled result register lets a flush drop the id_ex slot.
            if (flush && out_valid && !out_ready && unretired_count() > 1)
                flagged[flagged.size()-1] = 1'b1;
            if (in_valid && in_ready) begin
                pend.push_back(in_data);
                flagged.push_back(1'b0);
                seen_accept = 1'b1;
            end
            outstanding = unretired_count();
        end
    end

    a_stable: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else flag_error("Retire output changed while stalled.");

    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        (in_valid && in_ready) ##1 (!out_valid || out_ready)
        |=> out_valid && out_data.pc == $past(in_data.pc, 2))
        else flag_error("Result did not appear two cycles after acceptance.");

    a_idle: assert property (@(posedge clk) disable iff (!rstn)
        !seen_accept && !flush |-> !out_valid && in_ready)
        else flag_error("DUT not idle and ready after reset.");

    a_no_x0: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> !(out_data.wen && out_data.rd == cpu_pkg::nop_reg_addr))
        else flag_error("A write to x0 was reported.");

endmodule

//--- sim/alu_core_tb.sv
`timescale 1ns/1ps

module alu_core_tb;

    localparam int num_instr = 400;

    logic              clk;
    logic              rstn;
    logic              flush;
    logic              in_valid;
    logic              in_ready;
    pipe_pkg::fetch_t  in_data;
    logic              out_valid;
    logic              out_ready;
    pipe_pkg::retire_t out_data;
    logic              err;
    logic              ctrl_on;
    cpu_pkg::word_t    pc;

    alu_core dut_i (
        .clk(clk), .rstn(rstn), .flush(flush),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

    retire_checker chk_i (
        .clk(clk), .rstn(rstn), .flush(flush),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    always @(posedge err) stop_on_failure("Retire checker reported a failure.");

    // Random back-pressure and flush once the first instruction is in.
    always @(negedge clk) begin
        if (ctrl_on) begin
            out_ready = ($urandom % 4) != 0;
            flush     = ($urandom % 16) == 0;
        end
    end

    // Registers x0..x3 only, so dependent chains are dense.
    function automatic cpu_pkg::word_t random_instr();
        int             kind;
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        logic [2:0]     f3;
        logic [6:0]     f7;
        logic [11:0]    imm;
        logic [6:0]     opc;
        kind = $urandom % 10;
        rd   = 5'($urandom % 4);
        rs1  = 5'($urandom % 4);
        rs2  = 5'($urandom % 4);
        f3   = 3'($urandom);
        f7   = (($urandom % 4) == 0) ? 7'b0100000 : 7'b0000000;
        imm  = 12'($urandom);
        if (kind < 4)
            return {f7, rs2, rs1, f3, rd, cpu_pkg::op_op};
        if (kind < 7) begin
            if (f3 == cpu_pkg::f3_sll || f3 == cpu_pkg::f3_srl_sra)
                imm[11:5] = f7;
            return {imm, rs1, f3, rd, cpu_pkg::op_imm};
        end
        if (kind == 7)
            return {20'($urandom), rd, cpu_pkg::op_lui};
        if (kind == 8)
            return {20'($urandom), rd, cpu_pkg::op_auipc};
        opc = 7'($urandom);
        if (opc == cpu_pkg::op_op || opc == cpu_pkg::op_imm ||
            opc == cpu_pkg::op_lui || opc == cpu_pkg::op_auipc)
            opc = opc ^ 7'b0000001; // Force an unsupported opcode.
        return {25'($urandom), opc};
    endfunction

    task automatic send_instr(input cpu_pkg::word_t instr);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid      = 1'b1;
        in_data.pc    = pc;
        in_data.instr = instr;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 100)
                stop_on_failure("Timeout: instruction was never accepted.");
        end while (!(in_valid && in_ready));
        pc = pc + 4;
    endtask

    task automatic drain_pipeline();
        int waited;
        int idle;
        waited = 0;
        idle   = 0;
        while (idle < 4) begin
            @(posedge clk);
            idle = out_valid ? 0 : idle + 1;
            waited++;
            if (waited > 50)
                stop_on_failure("Timeout: pipeline did not drain.");
        end
    endtask

    initial begin
        void'($urandom(98));
        rstn      = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        ctrl_on   = 1'b0;
        pc        = 32'h0000_1000;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (2) @(negedge clk);

        for (int i = 0; i < num_instr; i++) begin
            send_instr(random_instr());
            ctrl_on = 1'b1;
            if (($urandom % 6) == 0) begin
                @(negedge clk);
                in_valid = 1'b0;  // Empty slot gives a bubble.
            end
        end

        @(negedge clk);
        in_valid  = 1'b0;
        ctrl_on   = 1'b0;
        flush     = 1'b0;
        out_ready = 1'b1;
        drain_pipeline();

        if (err || chk_i.retired == 0 || chk_i.outstanding != 0) begin
            stop_on_failure("Accepted instructions were lost or none retired.");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- alu_core.f
hw/cpu_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/id_stage.sv
hw/id_ex.sv
hw/ex_stage.sv
hw/wb_stage.sv
hw/alu_core.sv
sim/retire_checker.sv
sim/alu_core_tb.sv
